// ==== logic/mem_path_cfg_pkg.sv ====
`default_nettype none

package mem_path_cfg_pkg;

  // cpu ports sharing the memory port
  localparam int NUM_PORTS = 2;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // per-lane request queue depth in the arbiter
  localparam int REQ_CREDITS = 2;

  // response queue depth in the router
  localparam int RESP_CREDITS = 4;

  // lane index carried with each memory request
  localparam int ID_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

endpackage

`default_nettype wire

// ==== logic/mem_path_txn_pkg.sv ====
`default_nettype none

package mem_path_txn_pkg;

  import mem_path_cfg_pkg::*;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  // adel covers loads and fetches, ades covers stores
  typedef enum logic [1:0] {
    exc_none = 2'd0,
    exc_adel = 2'd1,
    exc_ades = 2'd2
  } exc_t;

  // unmapped segments, kseg0 cached and kseg1 uncached
  localparam logic [ADDR_W-1:0] KSEG0_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] KSEG1_BASE = 32'hA000_0000;
  localparam logic [ADDR_W-1:0] KSEG2_BASE = 32'hC000_0000;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                wr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                cached;
    logic [ID_W-1:0]     id;
  } mem_req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
  } mem_resp_t;

endpackage

`default_nettype wire

// ==== logic/credit_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         store [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // sender tracks free space, so a push is always taken
  assign not_empty = (count != '0);
  assign do_pop    = pop & not_empty;
  assign head      = store[rd_ptr];

  // one credit back to the sender per entry freed
  assign credit = do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      store[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/access_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module access_lane #(
  parameter int REQ_CREDITS = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // cpu side, sram-like
  input  logic                                  req,
  input  logic                                  wr,
  input  mem_path_txn_pkg::access_size_t        size,
  input  logic [mem_path_cfg_pkg::ADDR_W-1:0]   addr,
  input  logic [mem_path_cfg_pkg::DATA_W-1:0]   wdata,
  output logic                                  addr_ok,
  output logic                                  data_ok,
  output logic [mem_path_cfg_pkg::DATA_W-1:0]   rdata,
  output mem_path_txn_pkg::exc_t                exc,
  // towards the arbiter
  output logic                                  lane_valid,
  output logic [mem_path_cfg_pkg::ADDR_W-1:0]   lane_addr,
  output logic                                  lane_wr,
  output logic [mem_path_cfg_pkg::DATA_W-1:0]   lane_wdata,
  output logic [mem_path_cfg_pkg::DATA_W/8-1:0] lane_wstrb,
  output logic                                  lane_cached,
  input  logic                                  lane_credit,
  // from the router
  input  logic                                  resp_valid,
  input  logic [mem_path_cfg_pkg::DATA_W-1:0]   resp_rdata
);

  import mem_path_cfg_pkg::*;
  import mem_path_txn_pkg::*;

  localparam int CRED_W = $clog2(REQ_CREDITS + 1);
  localparam int OUT_W  = 4;

  logic [CRED_W-1:0] credit_cnt;
  logic [OUT_W-1:0]  outstanding;
  logic              in_kseg0;
  logic              in_kseg1;
  logic              misaligned;
  logic              addr_err;
  logic              good_ok;
  logic              err_ok;
  logic              err_pend;
  exc_t              err_code;

  assign in_kseg0 = (addr >= KSEG0_BASE) && (addr < KSEG1_BASE);
  assign in_kseg1 = (addr >= KSEG1_BASE) && (addr < KSEG2_BASE);

  always_comb begin
    case (size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = addr[0];
      default:   misaligned = (addr[1:0] != 2'b00);
    endcase
  end

  // kuseg, kseg2 and kseg3 are not reachable without a tlb
  assign addr_err = ~(in_kseg0 | in_kseg1) | misaligned;

  always_comb begin
    case (size)
      size_byte: lane_wstrb = 4'b0001 << addr[1:0];
      size_half: lane_wstrb = addr[1] ? 4'b1100 : 4'b0011;
      default:   lane_wstrb = 4'b1111;
    endcase
  end

  // good access needs a queue credit, error waits for the lane to drain
  assign good_ok = req & ~addr_err & (credit_cnt != '0) & ~(&outstanding);
  assign err_ok  = req & addr_err & (outstanding == '0);
  assign addr_ok = good_ok | err_ok;

  assign lane_valid  = good_ok;
  assign lane_addr   = {3'b000, addr[ADDR_W-4:0]};
  assign lane_wr     = wr;
  assign lane_wdata  = wdata;
  assign lane_cached = in_kseg0;

  // error answer never overlaps a memory response
  assign data_ok = resp_valid | err_pend;
  assign rdata   = resp_valid ? resp_rdata : '0;
  assign exc     = err_pend ? err_code : exc_none;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt  <= CRED_W'(REQ_CREDITS);
      outstanding <= '0;
      err_pend    <= 1'b0;
    end else begin
      credit_cnt  <= credit_cnt + CRED_W'(lane_credit) - CRED_W'(lane_valid);
      outstanding <= outstanding + OUT_W'(good_ok) - OUT_W'(resp_valid);
      err_pend    <= err_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (err_ok) begin
      err_code <= wr ? exc_ades : exc_adel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
  parameter int NUM_PORTS   = 2,
  parameter int REQ_CREDITS = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [NUM_PORTS-1:0]                  lane_valid,
  input  logic [mem_path_cfg_pkg::ADDR_W-1:0]   lane_addr   [NUM_PORTS],
  input  logic [NUM_PORTS-1:0]                  lane_wr,
  input  logic [mem_path_cfg_pkg::DATA_W-1:0]   lane_wdata  [NUM_PORTS],
  input  logic [mem_path_cfg_pkg::DATA_W/8-1:0] lane_wstrb  [NUM_PORTS],
  input  logic [NUM_PORTS-1:0]                  lane_cached,
  output logic [NUM_PORTS-1:0]                  lane_credit,
  output logic                                  mem_req_valid,
  output logic [mem_path_cfg_pkg::ADDR_W-1:0]   mem_addr,
  output logic                                  mem_wr,
  output logic [mem_path_cfg_pkg::DATA_W-1:0]   mem_wdata,
  output logic [mem_path_cfg_pkg::DATA_W/8-1:0] mem_wstrb,
  output logic                                  mem_cached,
  output logic [mem_path_cfg_pkg::ID_W-1:0]     mem_id,
  input  logic                                  mem_req_ready
);

  import mem_path_cfg_pkg::*;
  import mem_path_txn_pkg::*;

  mem_req_t             q_push_data [NUM_PORTS];
  mem_req_t             q_head      [NUM_PORTS];
  logic [NUM_PORTS-1:0] q_not_empty;
  logic [NUM_PORTS-1:0] q_pop;
  logic [ID_W-1:0]      rr_ptr;
  logic [ID_W-1:0]      pick;
  logic [ID_W-1:0]      sel;
  logic [ID_W-1:0]      hold_sel;
  logic                 pick_found;
  logic                 hold_q;
  logic                 grant;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane_q
    assign q_push_data[p].addr   = lane_addr[p];
    assign q_push_data[p].wr     = lane_wr[p];
    assign q_push_data[p].wdata  = lane_wdata[p];
    assign q_push_data[p].wstrb  = lane_wstrb[p];
    assign q_push_data[p].cached = lane_cached[p];
    assign q_push_data[p].id     = ID_W'(p);
    assign q_pop[p]              = grant & (sel == ID_W'(p));

    credit_fifo #(
      .payload_t (mem_req_t),
      .DEPTH     (REQ_CREDITS)
    ) credit_fifo_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (lane_valid[p]),
      .push_data (q_push_data[p]),
      .pop       (q_pop[p]),
      .head      (q_head[p]),
      .not_empty (q_not_empty[p]),
      .credit    (lane_credit[p])
    );
  end

  // first non-empty queue at or after the pointer
  always_comb begin
    pick       = rr_ptr;
    pick_found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!pick_found && q_not_empty[(int'(rr_ptr) + i) % NUM_PORTS]) begin
        pick       = ID_W'((int'(rr_ptr) + i) % NUM_PORTS);
        pick_found = 1'b1;
      end
    end
  end

  // a request left waiting keeps its lane until memory takes it
  assign sel           = hold_q ? hold_sel : pick;
  assign mem_req_valid = hold_q | pick_found;
  assign grant         = mem_req_valid & mem_req_ready;

  assign mem_addr   = q_head[sel].addr;
  assign mem_wr     = q_head[sel].wr;
  assign mem_wdata  = q_head[sel].wdata;
  assign mem_wstrb  = q_head[sel].wstrb;
  assign mem_cached = q_head[sel].cached;
  assign mem_id     = q_head[sel].id;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr <= '0;
      hold_q <= 1'b0;
    end else begin
      hold_q <= mem_req_valid & ~mem_req_ready;
      if (grant) begin
        rr_ptr <= (sel == ID_W'(NUM_PORTS - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req_valid & ~mem_req_ready) begin
      hold_sel <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== logic/resp_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module resp_router #(
  parameter int NUM_PORTS    = 2,
  parameter int RESP_CREDITS = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                mem_resp_valid,
  input  logic [mem_path_cfg_pkg::ID_W-1:0]   mem_resp_id,
  input  logic [mem_path_cfg_pkg::DATA_W-1:0] mem_rdata,
  output logic                                mem_resp_credit,
  output logic [NUM_PORTS-1:0]                resp_valid,
  output logic [mem_path_cfg_pkg::DATA_W-1:0] resp_rdata
);

  import mem_path_cfg_pkg::*;
  import mem_path_txn_pkg::*;

  mem_resp_t push_data;
  mem_resp_t head;
  logic      not_empty;

  assign push_data.id    = mem_resp_id;
  assign push_data.rdata = mem_rdata;

  // lanes never stall, so the head drains every cycle
  credit_fifo #(
    .payload_t (mem_resp_t),
    .DEPTH     (RESP_CREDITS)
  ) credit_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (mem_resp_valid),
    .push_data (push_data),
    .pop       (not_empty),
    .head      (head),
    .not_empty (not_empty),
    .credit    (mem_resp_credit)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_dec
    assign resp_valid[p] = not_empty & (head.id == ID_W'(p));
  end

  assign resp_rdata = head.rdata;

endmodule

`default_nettype wire

// ==== logic/mem_path_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_path_top #(
  parameter int NUM_PORTS    = mem_path_cfg_pkg::NUM_PORTS,
  parameter int REQ_CREDITS  = mem_path_cfg_pkg::REQ_CREDITS,
  parameter int RESP_CREDITS = mem_path_cfg_pkg::RESP_CREDITS
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // cpu ports, one lane each
  input  logic [NUM_PORTS-1:0]                  req,
  input  logic [NUM_PORTS-1:0]                  wr,
  input  mem_path_txn_pkg::access_size_t        size     [NUM_PORTS],
  input  logic [mem_path_cfg_pkg::ADDR_W-1:0]   addr     [NUM_PORTS],
  input  logic [mem_path_cfg_pkg::DATA_W-1:0]   wdata    [NUM_PORTS],
  output logic [NUM_PORTS-1:0]                  addr_ok,
  output logic [NUM_PORTS-1:0]                  data_ok,
  output logic [mem_path_cfg_pkg::DATA_W-1:0]   rdata    [NUM_PORTS],
  output mem_path_txn_pkg::exc_t                exc      [NUM_PORTS],
  // memory request
  output logic                                  mem_req_valid,
  output logic [mem_path_cfg_pkg::ADDR_W-1:0]   mem_addr,
  output logic                                  mem_wr,
  output logic [mem_path_cfg_pkg::DATA_W-1:0]   mem_wdata,
  output logic [mem_path_cfg_pkg::DATA_W/8-1:0] mem_wstrb,
  output logic                                  mem_cached,
  output logic [mem_path_cfg_pkg::ID_W-1:0]     mem_id,
  input  logic                                  mem_req_ready,
  // memory response
  input  logic                                  mem_resp_valid,
  input  logic [mem_path_cfg_pkg::ID_W-1:0]     mem_resp_id,
  input  logic [mem_path_cfg_pkg::DATA_W-1:0]   mem_rdata,
  output logic                                  mem_resp_credit
);

  import mem_path_cfg_pkg::*;

  logic [NUM_PORTS-1:0] lane_valid;
  logic [NUM_PORTS-1:0] lane_wr;
  logic [NUM_PORTS-1:0] lane_cached;
  logic [NUM_PORTS-1:0] lane_credit;
  logic [ADDR_W-1:0]    lane_addr  [NUM_PORTS];
  logic [DATA_W-1:0]    lane_wdata [NUM_PORTS];
  logic [DATA_W/8-1:0]  lane_wstrb [NUM_PORTS];
  logic [NUM_PORTS-1:0] resp_valid;
  logic [DATA_W-1:0]    resp_rdata;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
    access_lane #(
      .REQ_CREDITS (REQ_CREDITS)
    ) access_lane_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req[p]),
      .wr          (wr[p]),
      .size        (size[p]),
      .addr        (addr[p]),
      .wdata       (wdata[p]),
      .addr_ok     (addr_ok[p]),
      .data_ok     (data_ok[p]),
      .rdata       (rdata[p]),
      .exc         (exc[p]),
      .lane_valid  (lane_valid[p]),
      .lane_addr   (lane_addr[p]),
      .lane_wr     (lane_wr[p]),
      .lane_wdata  (lane_wdata[p]),
      .lane_wstrb  (lane_wstrb[p]),
      .lane_cached (lane_cached[p]),
      .lane_credit (lane_credit[p]),
      .resp_valid  (resp_valid[p]),
      .resp_rdata  (resp_rdata)
    );
  end

  mem_arbiter #(
    .NUM_PORTS     (NUM_PORTS),
    .REQ_CREDITS   (REQ_CREDITS)
  ) mem_arbiter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lane_valid    (lane_valid),
    .lane_addr     (lane_addr),
    .lane_wr       (lane_wr),
    .lane_wdata    (lane_wdata),
    .lane_wstrb    (lane_wstrb),
    .lane_cached   (lane_cached),
    .lane_credit   (lane_credit),
    .mem_req_valid (mem_req_valid),
    .mem_addr      (mem_addr),
    .mem_wr        (mem_wr),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .mem_cached    (mem_cached),
    .mem_id        (mem_id),
    .mem_req_ready (mem_req_ready)
  );

  resp_router #(
    .NUM_PORTS       (NUM_PORTS),
    .RESP_CREDITS    (RESP_CREDITS)
  ) resp_router_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_id     (mem_resp_id),
    .mem_rdata       (mem_rdata),
    .mem_resp_credit (mem_resp_credit),
    .resp_valid      (resp_valid),
    .resp_rdata      (resp_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/mem_path_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_path_sva #(
  parameter int NUM_PORTS   = 2,
  parameter int REQ_CREDITS = 2
) (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic [NUM_PORTS-1:0]                  lane_valid,
  input logic [NUM_PORTS-1:0]                  lane_credit,
  input logic [NUM_PORTS-1:0]                  resp_valid,
  input logic [NUM_PORTS-1:0]                  addr_ok,
  input logic [NUM_PORTS-1:0]                  data_ok,
  input logic                                  mem_req_valid,
  input logic                                  mem_req_ready,
  input logic [mem_path_cfg_pkg::ADDR_W-1:0]   mem_addr,
  input logic                                  mem_wr,
  input logic [mem_path_cfg_pkg::DATA_W-1:0]   mem_wdata,
  input logic [mem_path_cfg_pkg::DATA_W/8-1:0] mem_wstrb,
  input logic                                  mem_cached,
  input logic [mem_path_cfg_pkg::ID_W-1:0]     mem_id
);

  import mem_path_cfg_pkg::*;

  localparam int CRED_W = $clog2(REQ_CREDITS + 1);

  int                fail_count = 0;
  logic [CRED_W-1:0] credits [NUM_PORTS];
  logic [NUM_PORTS-1:0] issued;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
    // a queue entry frees when memory takes a request of this lane
    assign issued[p] = mem_req_valid && mem_req_ready && (mem_id == ID_W'(p));

    // free queue space seen from the memory side
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        credits[p] <= CRED_W'(REQ_CREDITS);
      end else begin
        credits[p] <= credits[p] + CRED_W'(issued[p]) - CRED_W'(lane_valid[p]);
      end
    end

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      lane_valid[p] |-> (credits[p] != '0))
    else begin
      $error("lane %0d raised lane_valid without a credit", p);
      fail_count++;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_valid && !mem_req_ready) |=> mem_req_valid &&
      $stable({mem_addr, mem_wr, mem_wdata, mem_wstrb, mem_cached, mem_id}))
  else begin
    $error("memory request changed while waiting for ready");
    fail_count++;
  end

  a_resp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(resp_valid))
  else begin
    $error("more than one resp_valid high");
    fail_count++;
  end

  // first cycle out of reset is quiet on the cpu side
  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (addr_ok == '0) && (data_ok == '0))
  else begin
    $error("addr_ok or data_ok high right after reset");
    fail_count++;
  end

endmodule

bind mem_path_top mem_path_sva #(
  .NUM_PORTS     (NUM_PORTS),
  .REQ_CREDITS   (REQ_CREDITS)
) mem_path_sva_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .lane_valid    (lane_valid),
  .lane_credit   (lane_credit),
  .resp_valid    (resp_valid),
  .addr_ok       (addr_ok),
  .data_ok       (data_ok),
  .mem_req_valid (mem_req_valid),
  .mem_req_ready (mem_req_ready),
  .mem_addr      (mem_addr),
  .mem_wr        (mem_wr),
  .mem_wdata     (mem_wdata),
  .mem_wstrb     (mem_wstrb),
  .mem_cached    (mem_cached),
  .mem_id        (mem_id)
);

`default_nettype wire

// ==== verification/mem_path_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_path_tb;

  import mem_path_cfg_pkg::*;
  import mem_path_txn_pkg::*;

  localparam int CLK_HALF      = 50;
  localparam int RAND_PER_PORT = 120;
  // about 300 accesses at a worst-case latency of 20 cycles
  localparam int TIMEOUT_CYCLES = 300 * 20;

  typedef struct {
    logic [DATA_W-1:0] rdata;
    exc_t              exc;
    logic              check_rdata;
  } expect_t;

  typedef struct {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
    int                due;
  } pending_resp_t;

  logic                clk;
  logic                rst_n;
  logic [NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0] wr;
  access_size_t        size  [NUM_PORTS];
  logic [ADDR_W-1:0]   addr  [NUM_PORTS];
  logic [DATA_W-1:0]   wdata [NUM_PORTS];
  logic [NUM_PORTS-1:0] addr_ok;
  logic [NUM_PORTS-1:0] data_ok;
  logic [DATA_W-1:0]   rdata [NUM_PORTS];
  exc_t                exc   [NUM_PORTS];
  logic                mem_req_valid;
  logic [ADDR_W-1:0]   mem_addr;
  logic                mem_wr;
  logic [DATA_W-1:0]   mem_wdata;
  logic [DATA_W/8-1:0] mem_wstrb;
  logic                mem_cached;
  logic [ID_W-1:0]     mem_id;
  logic                mem_req_ready;
  logic                mem_resp_valid;
  logic [ID_W-1:0]     mem_resp_id;
  logic [DATA_W-1:0]   mem_rdata;
  logic                mem_resp_credit;

  integer              seed;
  integer              mem_seed;
  int                  errors;
  int                  tests_run;
  int                  tests_failed;
  int                  cycle_count;
  int                  mem_cyc;
  int                  mem_accepts;
  int                  resp_credits;
  int                  ready_pct;
  logic [ADDR_W-1:0]   last_mem_addr;
  logic                last_mem_cached;
  // expected image and the memory itself, keyed by physical word address
  logic [DATA_W-1:0]   shadow    [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0]   mem_words [logic [ADDR_W-1:0]];
  expect_t             exp_q     [NUM_PORTS][$];
  pending_resp_t       resp_q    [$];

  mem_path_top #(
    .NUM_PORTS       (NUM_PORTS),
    .REQ_CREDITS     (REQ_CREDITS),
    .RESP_CREDITS    (RESP_CREDITS)
  ) mem_path_top_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .wr              (wr),
    .size            (size),
    .addr            (addr),
    .wdata           (wdata),
    .addr_ok         (addr_ok),
    .data_ok         (data_ok),
    .rdata           (rdata),
    .exc             (exc),
    .mem_req_valid   (mem_req_valid),
    .mem_addr        (mem_addr),
    .mem_wr          (mem_wr),
    .mem_wdata       (mem_wdata),
    .mem_wstrb       (mem_wstrb),
    .mem_cached      (mem_cached),
    .mem_id          (mem_id),
    .mem_req_ready   (mem_req_ready),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_id     (mem_resp_id),
    .mem_rdata       (mem_rdata),
    .mem_resp_credit (mem_resp_credit)
  );

  // unmapped segments lose the top three bits
  function automatic logic [ADDR_W-1:0] phys_addr(input logic [ADDR_W-1:0] a);
    return {3'b000, a[ADDR_W-4:0]};
  endfunction

  // only 0x8..0xB in the top nibble is unmapped kernel space
  function automatic logic access_fault(input access_size_t sz, input logic [ADDR_W-1:0] a);
    logic unmapped;
    logic odd;
    unmapped = (a[31:30] != 2'b10);
    odd      = (sz == size_half) ? a[0] : (sz == size_word) ? (a[1:0] != 2'b00) : 1'b0;
    return unmapped | odd;
  endfunction

  function automatic logic [3:0] byte_mask(input access_size_t sz, input logic [1:0] lo);
    case (sz)
      size_byte: return 4'b0001 << lo;
      size_half: return 4'b0011 << {lo[1], 1'b0};
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return a ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [3:0]        mask);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] key);
    return shadow.exists(key) ? shadow[key] : fill_word(key);
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("simulation timed out after %0d cycles", cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  // memory model: accept, write, queue in-order responses
  always @(posedge clk) begin
    pending_resp_t     pr;
    logic [ADDR_W-1:0] key;
    mem_cyc++;
    if (!rst_n) begin
      resp_q.delete();
      resp_credits = RESP_CREDITS;
    end else begin
      if (mem_resp_valid) begin
        void'(resp_q.pop_front());
        resp_credits--;
      end
      if (mem_resp_credit) begin
        resp_credits++;
      end
      assert (resp_credits >= 0 && resp_credits <= RESP_CREDITS) else begin
        $display("response credit count out of range: %0d", resp_credits);
        errors++;
      end
      if (mem_req_valid && mem_req_ready) begin
        key      = {mem_addr[ADDR_W-1:2], 2'b00};
        pr.id    = mem_id;
        pr.rdata = '0;
        pr.due   = mem_cyc + int'({$random(mem_seed)} % 5);
        if (mem_wr) begin
          mem_words[key] = merge_bytes(mem_words.exists(key) ? mem_words[key] : fill_word(key),
                                       mem_wdata, mem_wstrb);
        end else begin
          pr.rdata = mem_words.exists(key) ? mem_words[key] : fill_word(key);
        end
        resp_q.push_back(pr);
        mem_accepts++;
        last_mem_addr   = mem_addr;
        last_mem_cached = mem_cached;
      end
    end
  end

  always @(negedge clk) begin
    mem_req_ready = rst_n && (({$random(mem_seed)} % 100) < ready_pct);
    // stall responses while out of credits
    if (rst_n && resp_q.size() != 0 && resp_q[0].due <= mem_cyc && resp_credits > 0) begin
      mem_resp_valid = 1'b1;
      mem_resp_id    = resp_q[0].id;
      mem_rdata      = resp_q[0].rdata;
    end else begin
      mem_resp_valid = 1'b0;
    end
  end

  // every data_ok against the expected queue of its port
  always @(posedge clk) begin
    expect_t e;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (!rst_n) begin
        exp_q[p].delete();
      end else if (data_ok[p]) begin
        assert (exp_q[p].size() != 0) else begin
          $display("port %0d gave data_ok with nothing outstanding at %0t", p, $time);
          errors++;
        end
        if (exp_q[p].size() != 0) begin
          e = exp_q[p].pop_front();
          assert (exc[p] == e.exc) else begin
            $display("Mismatch at %0t: port %0d exc %0d, expected %0d", $time, p, exc[p], e.exc);
            errors++;
          end
          assert (!e.check_rdata || rdata[p] == e.rdata) else begin
            $display("Mismatch at %0t: port %0d rdata %h, expected %h",
                     $time, p, rdata[p], e.rdata);
            errors++;
          end
        end
      end
    end
  end

  task automatic issue(input int p, input logic w, input access_size_t sz,
                       input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    expect_t           e;
    logic [ADDR_W-1:0] key;
    logic              fault;
    fault = access_fault(sz, a);
    key   = phys_addr(a);
    key[1:0] = 2'b00;
    @(negedge clk);
    req[p]   = 1'b1;
    wr[p]    = w;
    size[p]  = sz;
    addr[p]  = a;
    wdata[p] = d;
    @(posedge clk);
    while (!addr_ok[p]) begin
      @(posedge clk);
    end
    e.check_rdata = fault | ~w;
    e.exc         = fault ? (w ? exc_ades : exc_adel) : exc_none;
    e.rdata       = '0;
    if (!fault && w) begin
      shadow[key] = merge_bytes(shadow_word(key), d, byte_mask(sz, a[1:0]));
    end else if (!fault) begin
      e.rdata = shadow_word(key);
    end
    exp_q[p].push_back(e);
    @(negedge clk);
    req[p] = 1'b0;
    if (fault) begin
      @(posedge clk);
      assert (data_ok[p]) else begin
        $display("port %0d error access not answered one cycle after addr_ok", p);
        errors++;
      end
    end
  endtask

  task automatic drain();
    while (pending_total() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // per-port region, with some kuseg and misaligned accesses mixed in
  task automatic random_traffic(input int p);
    integer            s;
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] a;
    access_size_t      sz;
    logic [1:0]        low;
    s = seed + 1 + p;
    for (int n = 0; n < RAND_PER_PORT; n++) begin
      rnd = $random(s);
      sz  = (rnd[5:4] == 2'd0) ? size_byte : (rnd[5:4] == 2'd1) ? size_half : size_word;
      low = (sz == size_byte) ? rnd[12:11] : (sz == size_half) ? {rnd[12], 1'b0} : 2'b00;
      a   = (rnd[13] ? KSEG0_BASE : KSEG1_BASE) + 32'((p + 1) << 12) + {rnd[10:7], 2'b00} + low;
      if (rnd[3:0] == 4'd0) begin
        a[31:28] = 4'h0;
      end else if (rnd[3:0] == 4'd1) begin
        sz   = size_word;
        a[0] = 1'b1;
      end
      issue(p, rnd[6], sz, a, $random(s));
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  initial begin
    int start_errors;
    int start_accepts;
    seed         = 15435;
    mem_seed     = seed;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    mem_cyc      = 0;
    mem_accepts  = 0;
    resp_credits = RESP_CREDITS;
    ready_pct    = 70;
    rst_n        = 1'b0;
    req          = '0;
    wr           = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      size[p]  = size_word;
      addr[p]  = '0;
      wdata[p] = '0;
    end
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_id    = '0;
    mem_rdata      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_errors = errors;
    issue(0, 1'b1, size_word, KSEG1_BASE + 32'h100, 32'hCAFE_F00D);
    issue(0, 1'b0, size_word, KSEG1_BASE + 32'h100, '0);
    drain();
    assert (last_mem_addr == 32'h0000_0100 && !last_mem_cached) else begin
      $display("Mismatch at %0t: memory saw %h cached %b, expected 00000100 uncached",
               $time, last_mem_addr, last_mem_cached);
      errors++;
    end
    end_test("kseg1 store and load", start_errors);

    start_errors = errors;
    issue(1, 1'b0, size_word, KSEG0_BASE + 32'h100, '0);
    drain();
    assert (last_mem_cached) else begin
      $display("Mismatch at %0t: kseg0 load reached memory uncached", $time);
      errors++;
    end
    end_test("kseg0 alias load", start_errors);

    start_errors  = errors;
    start_accepts = mem_accepts;
    issue(0, 1'b0, size_word, 32'h0000_1000, '0);
    issue(1, 1'b1, size_half, KSEG1_BASE + 32'h201, 32'h0000_BEEF);
    drain();
    assert (mem_accepts == start_accepts) else begin
      $display("an address error access reached memory");
      errors++;
    end
    end_test("address errors", start_errors);

    start_errors = errors;
    issue(1, 1'b1, size_word, KSEG1_BASE + 32'h300, 32'h1122_3344);
    issue(1, 1'b1, size_byte, KSEG1_BASE + 32'h302, 32'h00AA_0000);
    issue(1, 1'b0, size_word, KSEG1_BASE + 32'h300, '0);
    drain();
    end_test("byte store merge", start_errors);

    start_errors = errors;
    ready_pct    = 35;
    fork
      random_traffic(0);
      random_traffic(1);
    join
    drain();
    end_test("random traffic under stalls", start_errors);

    // fill lane 0 with a stalled memory, then reset in the middle
    start_errors = errors;
    ready_pct    = 0;
    for (int i = 0; i < REQ_CREDITS; i++) begin
      issue(0, 1'b0, size_word, KSEG1_BASE + 32'h40 + 32'(4 * i), '0);
    end
    req[0]  = 1'b1;
    wr[0]   = 1'b0;
    size[0] = size_word;
    addr[0] = KSEG1_BASE + 32'h80;
    @(posedge clk);
    assert (!addr_ok[0]) else begin
      $display("port 0 accepted a request with no credits left");
      errors++;
    end
    @(negedge clk);
    req[0] = 1'b0;
    rst_n  = 1'b0;
    repeat (3) @(posedge clk);
    assert (addr_ok == '0 && data_ok == '0 && !mem_req_valid && !mem_resp_credit) else begin
      $display("control outputs not low during reset");
      errors++;
    end
    @(negedge clk);
    rst_n = 1'b1;
    // each lane must take a full set of requests again before memory drains
    for (int i = 0; i < REQ_CREDITS; i++) begin
      issue(0, 1'b0, size_word, KSEG1_BASE + 32'h40 + 32'(4 * i), '0);
      issue(1, 1'b0, size_word, KSEG0_BASE + 32'h300, '0);
    end
    ready_pct = 100;
    drain();
    end_test("mid-run reset", start_errors);

    errors = errors + mem_path_top_i.mem_path_sva_i.fail_count;
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_path.f ====
logic/mem_path_cfg_pkg.sv
logic/mem_path_txn_pkg.sv
logic/credit_fifo.sv
logic/access_lane.sv
logic/mem_arbiter.sv
logic/resp_router.sv
logic/mem_path_top.sv
verification/mem_path_sva.sv
verification/mem_path_tb.sv
